/* hw/fifo_pkg.sv */
// ####################
// sizes, register map and cfg word layout for the cdc fifo
// depth need not be a power of two, pointers carry one extra wrap bit
// ####################
`default_nettype none

package fifo_pkg;

   // fifo geometry
   localparam int FIFO_DW    = 16;                 // data word width
   localparam int FIFO_DEPTH = 6;                  // entries, not a power of two
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // memory index width
   localparam int FIFO_PW    = FIFO_AW + 1;        // pointer width incl. wrap bit

   // config register map
   localparam int   CFG_DW        = 16;
   localparam logic CFG_ADDR_CTRL = 1'b0;
   localparam logic CFG_ADDR_SEED = 1'b1;

   // lfsr constants, x^16 + x^14 + x^13 + x^11 + 1
   localparam logic [CFG_DW-1:0] LFSR_SEED_RST = 16'hACE1;
   localparam logic [CFG_DW-1:0] LFSR_TAPS     = 16'hB400; // right-shift galois mask

   // control view of a cfg word, chaos_en sits in bit 0
   typedef struct packed {
      logic [6:0] rsvd;         // reads back as zero
      logic [7:0] chaos_thresh; // lfsr low byte compare level
      logic       chaos_en;
   } cfg_ctrl_t;

   // one written word, two decodes picked by address
   typedef union packed {
      logic [CFG_DW-1:0] raw;  // seed view
      cfg_ctrl_t         ctrl; // control view
   } cfg_word_u;

endpackage

`default_nettype wire

/* hw/gray_sync.sv */
// ####################
// two-flop synchronizer for a gray pointer bus
// only safe because at most one bit changes per source clock
// ####################
`timescale 1ns/1ps
`default_nettype none

module gray_sync
   import fifo_pkg::*;
(
   input  wire              clk,      // destination clock
   input  wire              nreset,
   input  wire  [FIFO_PW-1:0] gray_in,  // from source domain
   output logic [FIFO_PW-1:0] gray_out  // two stages later
);

   logic [FIFO_PW-1:0] meta_q; // first stage, may go metastable

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         meta_q   <= '0;
         gray_out <= '0;
      end
      else
      begin
         meta_q   <= gray_in;
         gray_out <= meta_q;
      end

endmodule

`default_nettype wire

/* hw/chaos_lfsr.sv */
// ####################
// galois lfsr that raises a random full level in the write domain
// thresh 0 never fires, 255 fires on all but one low byte value
// ####################
`timescale 1ns/1ps
`default_nettype none

module chaos_lfsr
   import fifo_pkg::*;
(
   input  wire              wr_clk,
   input  wire              wr_nreset,
   input  wire              chaos_en,     // gate for the random full
   input  wire  [7:0]       chaos_thresh, // higher means more often
   input  wire  [CFG_DW-1:0] seed,
   input  wire              seed_load,    // one cycle pulse
   output logic             chaos_full
);

   logic [CFG_DW-1:0] lfsr_q;
   logic [CFG_DW-1:0] lfsr_step; // next state when free running
   logic [CFG_DW-1:0] load_val;

   // shift right, fold taps in when lsb drops out
   assign lfsr_step = {1'b0, lfsr_q[CFG_DW-1:1]} ^ (lfsr_q[0] ? LFSR_TAPS : '0);

   // all-zero state would lock up
   assign load_val = (seed == '0) ? LFSR_SEED_RST : seed;

   always_ff @(posedge wr_clk or negedge wr_nreset)
      if (!wr_nreset)
         lfsr_q <= LFSR_SEED_RST;
      else if (seed_load)
         lfsr_q <= load_val;   // reseed wins over stepping
      else
         lfsr_q <= lfsr_step;  // steps every cycle

   // unsigned compare on the low byte
   assign chaos_full = chaos_en && (lfsr_q[7:0] < chaos_thresh);

endmodule

`default_nettype wire

/* hw/fifo_cfg_regs.sv */
// ####################
// write-domain config registers, addr 0 control and addr 1 lfsr seed
// cfg_rdata is combinational, valid the cycle after a strobe
// ####################
`timescale 1ns/1ps
`default_nettype none

module fifo_cfg_regs
   import fifo_pkg::*;
(
   input  wire               wr_clk,
   input  wire               wr_nreset,
   input  wire               cfg_wr,       // one cycle write strobe
   input  wire               cfg_addr,
   input  wire  cfg_word_u   cfg_wdata,
   output cfg_word_u         cfg_rdata,
   output logic              chaos_en,
   output logic [7:0]        chaos_thresh,
   output logic [CFG_DW-1:0] seed,
   output logic              seed_load     // pulses after a seed write
);

   logic ctrl_wr;
   logic seed_wr;

   // address decode
   assign ctrl_wr = cfg_wr && (cfg_addr == CFG_ADDR_CTRL);
   assign seed_wr = cfg_wr && (cfg_addr == CFG_ADDR_SEED);

   always_ff @(posedge wr_clk or negedge wr_nreset)
      if (!wr_nreset)
      begin
         chaos_en     <= 1'b0;
         chaos_thresh <= '0;
         seed         <= LFSR_SEED_RST;
         seed_load    <= 1'b0;
      end
      else
      begin
         seed_load <= seed_wr; // lfsr picks up the new seed one edge later
         if (ctrl_wr)
         begin
            chaos_en     <= cfg_wdata.ctrl.chaos_en;     // control decode
            chaos_thresh <= cfg_wdata.ctrl.chaos_thresh;
         end
         if (seed_wr)
            seed <= cfg_wdata.raw;                       // raw decode
      end

   // readback mux, reserved ctrl bits stay zero
   always_comb
   begin
      cfg_rdata = '0;
      if (cfg_addr == CFG_ADDR_SEED)
         cfg_rdata.raw = seed;
      else
      begin
         cfg_rdata.ctrl.chaos_en     = chaos_en;
         cfg_rdata.ctrl.chaos_thresh = chaos_thresh;
      end
   end

endmodule

`default_nettype wire

/* hw/async_fifo.sv */
// ####################
// dual-clock fifo, gray pointers crossed by two-flop syncs
// full is occupancy based so any depth works, empty is a gray compare
// rd_dout is combinational from the head entry and only valid when not empty
// ####################
`timescale 1ns/1ps
`default_nettype none

module async_fifo
   import fifo_pkg::*;
(
   // write domain
   input  wire                wr_clk,
   input  wire                wr_nreset,
   input  wire  [FIFO_DW-1:0] wr_din,
   input  wire                wr_en,
   input  wire                chaos_full, // random back-pressure request
   output logic               wr_full,
   // read domain
   input  wire                rd_clk,
   input  wire                rd_nreset,
   input  wire                rd_en,
   output logic [FIFO_DW-1:0] rd_dout,
   output logic               rd_empty
);

   // write side state
   logic [FIFO_PW-1:0] wr_bin;      // free running, wraps at 2**FIFO_PW
   logic [FIFO_PW-1:0] wr_gray;     // crossed to read side
   logic [FIFO_AW-1:0] wr_idx;      // memory slot, wraps at FIFO_DEPTH
   logic [FIFO_PW-1:0] wr_bin_nxt;
   logic [FIFO_PW-1:0] wr_gray_nxt;
   logic [FIFO_AW-1:0] wr_idx_nxt;
   logic [FIFO_PW-1:0] wr_used;     // occupancy seen from write side
   logic [FIFO_PW-1:0] wr_used_nxt;
   logic               wr_push;
   logic [FIFO_PW-1:0] rd_gray_sync;
   logic [FIFO_PW-1:0] rd_bin_sync;

   // read side state
   logic [FIFO_PW-1:0] rd_bin;
   logic [FIFO_PW-1:0] rd_gray;
   logic [FIFO_AW-1:0] rd_idx;
   logic [FIFO_PW-1:0] rd_bin_nxt;
   logic [FIFO_PW-1:0] rd_gray_nxt;
   logic [FIFO_AW-1:0] rd_idx_nxt;
   logic               rd_pop;
   logic [FIFO_PW-1:0] wr_gray_sync;

   logic [FIFO_DW-1:0] mem [FIFO_DEPTH]; // storage, no reset

   // ####################
   // write side
   // ####################

   assign wr_push     = wr_en && !wr_full;            // drop writes while full
   assign wr_bin_nxt  = wr_bin + FIFO_PW'(wr_push);
   assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);

   // slot index skips the unused top addresses
   always_comb
   begin
      wr_idx_nxt = wr_idx;
      if (wr_push)
         wr_idx_nxt = (wr_idx == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
   end

   always_ff @(posedge wr_clk or negedge wr_nreset)
      if (!wr_nreset)
      begin
         wr_bin  <= '0;
         wr_gray <= '0;
         wr_idx  <= '0;
      end
      else
      begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= wr_gray_nxt;
         wr_idx  <= wr_idx_nxt;
      end

   // synced read pointer back to binary, msb first
   always_comb
   begin
      rd_bin_sync[FIFO_PW-1] = rd_gray_sync[FIFO_PW-1];
      for (int i = FIFO_PW - 2; i >= 0; i--)
         rd_bin_sync[i] = rd_bin_sync[i+1] ^ rd_gray_sync[i];
   end

   // modulo subtract, the wrap bit keeps a full fifo apart from an empty one
   assign wr_used     = wr_bin - rd_bin_sync;
   assign wr_used_nxt = wr_used + FIFO_PW'(wr_push); // after this edge

   always_ff @(posedge wr_clk or negedge wr_nreset)
      if (!wr_nreset)
         wr_full <= 1'b0;
      else
         wr_full <= chaos_full || (wr_used_nxt == FIFO_PW'(FIFO_DEPTH));

   // read pointer into write clock
   gray_sync i_rd2wr_sync
   (
      .clk      (wr_clk),
      .nreset   (wr_nreset),
      .gray_in  (rd_gray),
      .gray_out (rd_gray_sync)
   );

   // ####################
   // read side
   // ####################

   assign rd_pop      = rd_en && !rd_empty;           // ignore reads while empty
   assign rd_bin_nxt  = rd_bin + FIFO_PW'(rd_pop);
   assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

   always_comb
   begin
      rd_idx_nxt = rd_idx;
      if (rd_pop)
         rd_idx_nxt = (rd_idx == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_idx + 1'b1;
   end

   always_ff @(posedge rd_clk or negedge rd_nreset)
      if (!rd_nreset)
      begin
         rd_bin   <= '0;
         rd_gray  <= '0;
         rd_idx   <= '0;
         rd_empty <= 1'b1;
      end
      else
      begin
         rd_bin   <= rd_bin_nxt;
         rd_gray  <= rd_gray_nxt;
         rd_idx   <= rd_idx_nxt;
         rd_empty <= (rd_gray_nxt == wr_gray_sync); // caught up with writer
      end

   // write pointer into read clock
   gray_sync i_wr2rd_sync
   (
      .clk      (rd_clk),
      .nreset   (rd_nreset),
      .gray_in  (wr_gray),
      .gray_out (wr_gray_sync)
   );

   // ####################
   // storage
   // ####################

   always_ff @(posedge wr_clk)
      if (wr_push)
         mem[wr_idx] <= wr_din;

   assign rd_dout = mem[rd_idx]; // head entry, moves right after a pop

endmodule

`default_nettype wire

/* hw/cdc_fifo_top.sv */
// ####################
// cdc fifo with write-side config regs and chaos full generator
// config bus lives in the write clock domain only
// ####################
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_top
   import fifo_pkg::*;
(
   // clocking
   input  wire                wr_clk,
   input  wire                wr_nreset,
   input  wire                rd_clk,
   input  wire                rd_nreset,
   // write port
   input  wire  [FIFO_DW-1:0] wr_din,
   input  wire                wr_en,
   output logic               wr_full,
   // read port
   output logic [FIFO_DW-1:0] rd_dout,
   input  wire                rd_en,
   output logic               rd_empty,
   // config bus
   input  wire                cfg_wr,
   input  wire                cfg_addr,
   input  wire  cfg_word_u    cfg_wdata,
   output cfg_word_u          cfg_rdata
);

   logic              chaos_en;
   logic [7:0]        chaos_thresh;
   logic [CFG_DW-1:0] seed;
   logic              seed_load;
   logic              chaos_full; // lfsr to fifo full

   fifo_cfg_regs i_fifo_cfg_regs
   (
      .wr_clk       (wr_clk),
      .wr_nreset    (wr_nreset),
      .cfg_wr       (cfg_wr),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .cfg_rdata    (cfg_rdata),
      .chaos_en     (chaos_en),
      .chaos_thresh (chaos_thresh),
      .seed         (seed),
      .seed_load    (seed_load)
   );

   chaos_lfsr i_chaos_lfsr
   (
      .wr_clk       (wr_clk),
      .wr_nreset    (wr_nreset),
      .chaos_en     (chaos_en),
      .chaos_thresh (chaos_thresh),
      .seed         (seed),
      .seed_load    (seed_load),
      .chaos_full   (chaos_full)
   );

   async_fifo i_async_fifo
   (
      .wr_clk     (wr_clk),
      .wr_nreset  (wr_nreset),
      .wr_din     (wr_din),
      .wr_en      (wr_en),
      .chaos_full (chaos_full),
      .wr_full    (wr_full),
      .rd_clk     (rd_clk),
      .rd_nreset  (rd_nreset),
      .rd_en      (rd_en),
      .rd_dout    (rd_dout),
      .rd_empty   (rd_empty)
   );

endmodule

`default_nettype wire

/* bench/tb_cdc_fifo.sv */
// ####################
// testbench for cdc_fifo_top, a step table walked in order
// chaos stream at thresh 255 runs long since writes rarely get through
// ####################
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_fifo
   import fifo_pkg::*;
();

   // step opcodes and stream modes
   localparam logic [3:0] OP_RESET_CHK = 4'd0;
   localparam logic [3:0] OP_CFG_WR    = 4'd1;
   localparam logic [3:0] OP_CFG_RD    = 4'd2;
   localparam logic [3:0] OP_STREAM    = 4'd3;
   localparam logic [3:0] OP_FILL      = 4'd4;
   localparam logic [3:0] OP_DRAIN     = 4'd5;
   localparam int MODE_PLAIN  = 0;
   localparam int MODE_CHAOS  = 1; // random full must show up
   localparam int MODE_QUIET  = 2; // no early full once settled
   localparam int NSTEPS      = 17;
   localparam int SETTLE_NS   = 100; // pop to wr_full path, sync plus register
   localparam int SYNC_CYCLES = 4;

   // count doubles as address for cfg steps, exp as mode for streams
   typedef struct packed {
      logic [3:0]  op;
      logic [15:0] count;
      logic [15:0] cfg;
      logic [15:0] exp;
   } step_t;

   logic               wr_clk;
   logic               rd_clk;
   logic               wr_nreset;
   logic               rd_nreset;
   logic [FIFO_DW-1:0] wr_din;
   logic               wr_en;
   logic               wr_full;
   logic [FIFO_DW-1:0] rd_dout;
   logic               rd_en;
   logic               rd_empty;
   logic               cfg_wr;
   logic               cfg_addr;
   cfg_word_u          cfg_wdata;
   cfg_word_u          cfg_rdata;

   step_t              steps [NSTEPS];
   logic               table_ready;
   logic [FIFO_DW-1:0] sb [$];       // words accepted, not yet read
   logic [31:0]        lcg_state;
   logic               chaos_seen;
   time                last_pop;

   cdc_fifo_top i_cdc_fifo_top
   (
      .wr_clk    (wr_clk),
      .wr_nreset (wr_nreset),
      .rd_clk    (rd_clk),
      .rd_nreset (rd_nreset),
      .wr_din    (wr_din),
      .wr_en     (wr_en),
      .wr_full   (wr_full),
      .rd_dout   (rd_dout),
      .rd_en     (rd_en),
      .rd_empty  (rd_empty),
      .cfg_wr    (cfg_wr),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata)
   );

   initial
   begin
      wr_clk = 1'b0;
      forever #10 wr_clk = ~wr_clk; // 20 ns
   end

   initial
   begin
      rd_clk = 1'b0;
      forever #7 rd_clk = ~rd_clk;  // 14 ns, never lines up with wr rising edges
   end

   // ####################
   // helpers
   // ####################

   function automatic logic [31:0] rand_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {16'h0, lcg_state[31:16]}; // upper half, low bits cycle fast
   endfunction

   task automatic report_error(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp)
         report_error($sformatf("[FAIL] t=%0t %s got 0x%0h expected 0x%0h",
                                $time, name, got, exp));
   endtask

   task automatic load_table();
      steps[0]  = '{OP_RESET_CHK, 16'd0,   16'h0000, 16'h0000};
      steps[1]  = '{OP_CFG_RD,    16'd0,   16'h0000, 16'h0000};
      steps[2]  = '{OP_CFG_RD,    16'd1,   16'h0000, LFSR_SEED_RST};
      steps[3]  = '{OP_CFG_WR,    16'd0,   16'hFE54, 16'h0000}; // rsvd set, chaos off
      steps[4]  = '{OP_CFG_RD,    16'd0,   16'h0000, 16'h0054};
      steps[5]  = '{OP_CFG_WR,    16'd1,   16'h1234, 16'h0000};
      steps[6]  = '{OP_CFG_RD,    16'd1,   16'h0000, 16'h1234};
      steps[7]  = '{OP_STREAM,    16'd200, 16'h0000, 16'(MODE_PLAIN)};
      steps[8]  = '{OP_FILL,      16'(FIFO_DEPTH), 16'h0000, 16'h0001};
      steps[9]  = '{OP_DRAIN,     16'(FIFO_DEPTH), 16'h0000, 16'h0001};
      steps[10] = '{OP_CFG_WR,    16'd1,   16'hBEEF, 16'h0000};
      steps[11] = '{OP_CFG_WR,    16'd0,   16'h01FF, 16'h0000}; // thresh 255, on
      steps[12] = '{OP_CFG_RD,    16'd0,   16'h0000, 16'h01FF};
      steps[13] = '{OP_STREAM,    16'd200, 16'h0000, 16'(MODE_CHAOS)};
      steps[14] = '{OP_CFG_WR,    16'd0,   16'h0001, 16'h0000}; // thresh 0
      steps[15] = '{OP_CFG_RD,    16'd0,   16'h0000, 16'h0001};
      steps[16] = '{OP_STREAM,    16'd200, 16'h0000, 16'(MODE_QUIET)};
   endtask

   function automatic int watchdog_cycles();
      int cyc;
      cyc = 4 * NSTEPS * 200;
      for (int s = 0; s < NSTEPS; s++)
         if (steps[s].op == OP_STREAM && int'(steps[s].exp) == MODE_CHAOS)
            cyc += int'(steps[s].count) * 600; // about one free slot per 256 cycles
      return cyc;
   endfunction

   task automatic cfg_write(input logic addr, input logic [CFG_DW-1:0] val);
      @(negedge wr_clk);
      cfg_addr      = addr;
      cfg_wdata.raw = val;
      cfg_wr        = 1'b1;
      @(negedge wr_clk);
      cfg_wr = 1'b0;
   endtask

   task automatic cfg_read(input logic addr, input logic [CFG_DW-1:0] exp);
      @(negedge wr_clk);
      cfg_addr = addr;
      @(negedge wr_clk);
      check_val("cfg_rdata", 32'(cfg_rdata.raw), 32'(exp));
   endtask

   // ####################
   // write and read sides
   // ####################

   task automatic write_words(input int n, input int mode);
      int                 sent;
      logic               pending;
      logic [FIFO_DW-1:0] word;
      sent    = 0;
      pending = 1'b0;
      word    = '0;
      while (sent < n)
      begin
         @(negedge wr_clk);
         if (wr_full && sb.size() < FIFO_DEPTH)
            chaos_seen = 1'b1;
         if (mode == MODE_QUIET && sb.size() < FIFO_DEPTH - 2
             && ($time - last_pop) > SETTLE_NS)
            check_val("wr_full", 32'(wr_full), 32'(0));
         if (!pending && (rand_next() % 4 == 0))
            wr_en = 1'b0;                  // gap, only with no word held
         else
         begin
            if (!pending)
            begin
               word    = FIFO_DW'(rand_next());
               pending = 1'b1;
            end
            wr_din = word;                 // held while full
            wr_en  = 1'b1;
            if (!wr_full)
            begin
               sb.push_back(word);         // taken at the next rising edge
               sent++;
               pending = 1'b0;
            end
         end
      end
      @(negedge wr_clk);
      wr_en = 1'b0;
   endtask

   task automatic read_words(input int n);
      int                 got;
      logic [FIFO_DW-1:0] exp;
      got = 0;
      while (got < n)
      begin
         @(negedge rd_clk);
         if (rd_empty || (rand_next() % 3 == 0))
            rd_en = 1'b0;
         else if (sb.size() == 0)
            report_error("read side shows a word that was never written");
         else
         begin
            exp = sb.pop_front();
            check_val("rd_dout", 32'(rd_dout), 32'(exp));
            rd_en    = 1'b1;               // pops at the next rising edge
            last_pop = $time;
            got++;
         end
      end
      @(negedge rd_clk);
      rd_en = 1'b0;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while ((!rd_empty || wr_full) && n < 200)
      begin
         @(negedge wr_clk);
         n++;
      end
      if (n == 200)
         report_error("FIFO did not go idle before the fill");
      else
         repeat (SYNC_CYCLES) @(negedge wr_clk); // read pointer reaches write side
   endtask

   task automatic fill_words(input int n, input logic exp_full);
      logic [FIFO_DW-1:0] word;
      for (int i = 0; i < n + 2; i++)
      begin
         @(negedge wr_clk);
         word   = FIFO_DW'(rand_next());
         wr_din = word;
         wr_en  = 1'b1;
         if (i < n)
         begin
            check_val("wr_full", 32'(wr_full), 32'(0));
            sb.push_back(word);
         end
         else
            check_val("wr_full", 32'(wr_full), 32'(exp_full)); // extra writes dropped
      end
      @(negedge wr_clk);
      wr_en = 1'b0;
      check_val("wr_full", 32'(wr_full), 32'(exp_full));
   endtask

   task automatic run_step(input step_t st);
      case (st.op)
         OP_RESET_CHK:
         begin
            check_val("rd_empty", 32'(rd_empty), 32'(1));
            check_val("wr_full", 32'(wr_full), 32'(0));
         end
         OP_CFG_WR: cfg_write(st.count[0], st.cfg);
         OP_CFG_RD: cfg_read(st.count[0], st.exp);
         OP_STREAM:
         begin
            chaos_seen = 1'b0;
            fork
               write_words(int'(st.count), int'(st.exp));
               read_words(int'(st.count));
            join
            repeat (SYNC_CYCLES) @(negedge wr_clk); // write pointer reaches read side
            check_val("rd_empty", 32'(rd_empty), 32'(1)); // no extra or repeated word
            if (int'(st.exp) == MODE_CHAOS)
               check_val("chaos wr_full seen", 32'(chaos_seen), 32'(1));
         end
         OP_FILL:
         begin
            wait_idle();
            fill_words(int'(st.count), st.exp[0]);
         end
         OP_DRAIN:
         begin
            read_words(int'(st.count));
            check_val("rd_empty", 32'(rd_empty), 32'(st.exp)); // nothing extra got in
         end
         default: report_error("unknown opcode in the step table");
      endcase
   endtask

   // ####################
   // main and watchdog
   // ####################

   initial
   begin : main
      wr_nreset     = 1'b0;
      rd_nreset     = 1'b0;
      wr_din        = '0;
      wr_en         = 1'b0;
      rd_en         = 1'b0;
      cfg_wr        = 1'b0;
      cfg_addr      = 1'b0;
      cfg_wdata.raw = '0;
      lcg_state     = 32'd44906;
      chaos_seen    = 1'b0;
      last_pop      = 0;
      load_table();
      table_ready = 1'b1;
      repeat (2) @(posedge wr_clk);
      @(negedge wr_clk);
      wr_nreset = 1'b1;
      rd_nreset = 1'b1;
      for (int s = 0; s < NSTEPS; s++)
         run_step(steps[s]);
      $display("TEST OK");
      $finish;
   end

   initial
   begin : watchdog
      int budget;
      wait (table_ready);
      budget = watchdog_cycles();
      repeat (budget) @(posedge wr_clk);
      report_error("timeout: test did not finish");
   end

endmodule

`default_nettype wire

/* all.f */
hw/fifo_pkg.sv
hw/gray_sync.sv
hw/chaos_lfsr.sv
hw/fifo_cfg_regs.sv
hw/async_fifo.sv
hw/cdc_fifo_top.sv
bench/tb_cdc_fifo.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cdc_fifo
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
COMMON     := --timing --timescale 1ns/1ps -Wall -Wno-fatal
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 $(COMMON) --Mdir $(OBJ_DIR)
FAIL_MSG   := TEST FAILED
PASS_MSG   := TEST OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
